// File: design/vlsu_ctrl.sv
`timescale 1ns/1ps

module vlsu_ctrl import vlsu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Instruction from the core
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  logic      req_load_i,
  input  logic      req_strided_i,
  input  ew_e       req_vsew_i,
  input  elem_cnt_t req_vl_i,
  input  vreg_id_t  req_vd_i,
  input  addr_t     req_base_i,
  input  addr_t     req_stride_i,
  // Finished flags of the two sequencers
  input  logic      mem_done_i,
  input  logic      vrf_done_i,
  // Registered operation
  output logic      start_o,
  output logic      op_load_o,
  output ew_e       op_vsew_o,
  output elem_cnt_t op_vl_o,
  output vreg_id_t  op_vd_o,
  output addr_t     op_base_o,
  output addr_t     op_stride_o,
  // Completion
  output logic      rsp_valid_o,
  output vreg_id_t  rsp_vd_o
);

  vlsu_state_e state_q, state_d;
  logic        accept;

  logic        load_q;
  ew_e         vsew_q;
  elem_cnt_t   vl_q;
  vreg_id_t    vd_q;
  addr_t       base_q;
  addr_t       stride_q;

  assign req_ready_o = (state_q == ST_IDLE);
  assign accept      = req_valid_i & req_ready_o;

  // Counters in both sequencers restart on acceptance
  assign start_o = accept;

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = ST_BUSY;
        end
      end
      ST_BUSY: begin
        if (mem_done_i && vrf_done_i) begin
          state_d = ST_DONE;
        end
      end
      ST_DONE: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      vl_q    <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        vl_q <= req_vl_i;
      end
    end
  end

  // Instruction register, unit stride becomes the element size
  always_ff @(posedge clk_i) begin
    if (accept) begin
      load_q   <= req_load_i;
      vsew_q   <= req_vsew_i;
      vd_q     <= req_vd_i;
      base_q   <= req_base_i;
      stride_q <= req_strided_i ? req_stride_i : (addr_t'(1) << req_vsew_i);
    end
  end

  assign op_load_o   = load_q;
  assign op_vsew_o   = vsew_q;
  assign op_vl_o     = vl_q;
  assign op_vd_o     = vd_q;
  assign op_base_o   = base_q;
  assign op_stride_o = stride_q;

  assign rsp_valid_o = (state_q == ST_DONE);
  assign rsp_vd_o    = vd_q;

endmodule

// File: design/vlsu_elem_buffer.sv
`timescale 1ns/1ps

module vlsu_elem_buffer import vlsu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       push_i,
  input  word_t      wdata_i,
  input  logic [1:0] wlane_i,
  input  logic       reserve_i,
  input  logic       pop_i,
  output word_t      rdata_o,
  output logic [1:0] rlane_o,
  output logic       empty_o,
  output logic       full_o,
  output logic       grant_o
);

  word_t      data_q [BufDepth];
  logic [1:0] lane_q [BufDepth];
  buf_ptr_t   wr_ptr_q;
  buf_ptr_t   rd_ptr_q;
  buf_cnt_t   count_q;
  buf_cnt_t   resv_q;
  logic       do_push;
  logic       do_pop;
  logic       release_slot;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == BufDepth);
  assign do_push = push_i & !full_o;
  assign do_pop  = pop_i & !empty_o;

  // A load response fills a slot that was promised at issue
  assign release_slot = push_i & (resv_q != '0);
  assign grant_o      = ((count_q + resv_q) < BufDepth);

  assign rdata_o = data_q[rd_ptr_q];
  assign rlane_o = lane_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      resv_q   <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
      if (reserve_i && !release_slot) begin
        resv_q <= resv_q + 1'b1;
      end else if (release_slot && !reserve_i) begin
        resv_q <= resv_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      data_q[wr_ptr_q] <= wdata_i;
      lane_q[wr_ptr_q] <= wlane_i;
    end
  end

endmodule

// File: design/vlsu_mem_seq.sv
`timescale 1ns/1ps

module vlsu_mem_seq import vlsu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Operation
  input  logic       start_i,
  input  logic       op_load_i,
  input  ew_e        op_vsew_i,
  input  elem_cnt_t  op_vl_i,
  input  addr_t      op_base_i,
  input  addr_t      op_stride_i,
  // Memory request
  output logic       mem_valid_o,
  input  logic       mem_ready_i,
  output logic       mem_we_o,
  output addr_t      mem_addr_o,
  output strb_t      mem_strb_o,
  output word_t      mem_wdata_o,
  // Load response
  input  logic       mem_rvalid_i,
  // Element buffer
  input  logic       buf_grant_i,
  input  logic       buf_empty_i,
  input  word_t      buf_rdata_i,
  output logic       buf_reserve_o,
  output logic       buf_pop_o,
  output logic [1:0] buf_lane_o,
  output logic       done_o
);

  elem_cnt_t  cnt_q;
  elem_cnt_t  rsp_cnt_q;
  addr_t      off_q;
  addr_t      rsp_off_q;
  addr_t      req_addr;
  addr_t      rsp_addr;
  logic       more_beats;
  logic       fire;
  logic       rsp_fire;
  logic [1:0] lane;

  //////////////////////////////
  // Request side
  //////////////////////////////

  assign more_beats = (cnt_q < op_vl_i);

  // Loads need a free slot, stores need an element
  assign mem_valid_o = more_beats & (op_load_i ? buf_grant_i : !buf_empty_i);
  assign fire        = mem_valid_o & mem_ready_i;

  assign req_addr    = op_base_i + off_q;
  assign lane        = req_addr[1:0];

  assign mem_we_o    = !op_load_i;
  assign mem_addr_o  = {req_addr[31:2], 2'b00};
  assign mem_strb_o  = ew_mask(op_vsew_i) << lane;
  assign mem_wdata_o = rotl_bytes(buf_rdata_i, lane);

  assign buf_reserve_o = fire & op_load_i;
  assign buf_pop_o     = fire & !op_load_i;

  //////////////////////////////
  // Response side
  //////////////////////////////

  // Responses return in order, so a second address walk gives their lane
  assign rsp_fire   = op_load_i & mem_rvalid_i;
  assign rsp_addr   = op_base_i + rsp_off_q;
  assign buf_lane_o = rsp_addr[1:0];

  assign done_o = !more_beats & (!op_load_i | (rsp_cnt_q == op_vl_i));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q     <= '0;
      rsp_cnt_q <= '0;
    end else if (start_i) begin
      cnt_q     <= '0;
      rsp_cnt_q <= '0;
    end else begin
      if (fire) begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (rsp_fire) begin
        rsp_cnt_q <= rsp_cnt_q + 1'b1;
      end
    end
  end

  // Byte offsets from the base, one step of stride per element
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      off_q     <= '0;
      rsp_off_q <= '0;
    end else begin
      if (fire) begin
        off_q <= off_q + op_stride_i;
      end
      if (rsp_fire) begin
        rsp_off_q <= rsp_off_q + op_stride_i;
      end
    end
  end

endmodule

// File: design/vlsu_pkg.sv
package vlsu_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned DataWidth    = 32;
  localparam int unsigned DataBytes    = DataWidth / 8;
  localparam int unsigned NrVregs      = 32;
  localparam int unsigned WordsPerVreg = 4;
  localparam int unsigned VregBytes    = WordsPerVreg * DataBytes;
  localparam int unsigned BufDepth     = 4;
  localparam int unsigned BufPtrWidth  = $clog2(BufDepth);

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [DataWidth-1:0]                    word_t;
  typedef logic [DataBytes-1:0]                    strb_t;
  typedef logic [31:0]                             addr_t;
  typedef logic [$clog2(NrVregs)-1:0]              vreg_id_t;
  typedef logic [$clog2(NrVregs*WordsPerVreg)-1:0] vrf_addr_t;
  // One extra bit so that a full vector length fits
  typedef logic [$clog2(VregBytes):0]              elem_cnt_t;
  typedef logic [BufPtrWidth-1:0]                  buf_ptr_t;
  typedef logic [BufPtrWidth:0]                    buf_cnt_t;

  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } ew_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUSY = 2'd1,
    ST_DONE = 2'd2
  } vlsu_state_e;

  // Byte mask of one element, right aligned
  function automatic strb_t ew_mask(ew_e ew);
    strb_t mask;
    unique case (ew)
      EW_8:    mask = strb_t'(1);
      EW_16:   mask = strb_t'(3);
      default: mask = '1;
    endcase
    return mask;
  endfunction

  // Rotate a word left by whole bytes
  function automatic word_t rotl_bytes(word_t w, logic [1:0] n);
    logic [2*DataWidth-1:0] dbl;
    dbl = {w, w} << (8 * n);
    return dbl[2*DataWidth-1 -: DataWidth];
  endfunction

endpackage

// File: design/vlsu_top.sv
`timescale 1ns/1ps

module vlsu_top import vlsu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Instruction
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  logic      req_load_i,
  input  logic      req_strided_i,
  input  ew_e       req_vsew_i,
  input  elem_cnt_t req_vl_i,
  input  vreg_id_t  req_vd_i,
  input  addr_t     req_base_i,
  input  addr_t     req_stride_i,
  // Response
  output logic      rsp_valid_o,
  output vreg_id_t  rsp_vd_o,
  // Memory
  output logic      mem_valid_o,
  input  logic      mem_ready_i,
  output logic      mem_we_o,
  output addr_t     mem_addr_o,
  output strb_t     mem_strb_o,
  output word_t     mem_wdata_o,
  input  logic      mem_rvalid_i,
  input  word_t     mem_rdata_i,
  // Register file
  output logic      vrf_we_o,
  output vrf_addr_t vrf_waddr_o,
  output strb_t     vrf_wbe_o,
  output word_t     vrf_wdata_o,
  output logic      vrf_re_o,
  output vrf_addr_t vrf_raddr_o,
  input  logic      vrf_rvalid_i,
  input  word_t     vrf_rdata_i
);

  logic       start;
  logic       op_load;
  ew_e        op_vsew;
  elem_cnt_t  op_vl;
  vreg_id_t   op_vd;
  addr_t      op_base;
  addr_t      op_stride;
  logic       mem_done;
  logic       vrf_done;

  logic       buf_push;
  word_t      buf_wdata;
  logic [1:0] buf_wlane;
  logic       buf_reserve;
  logic       buf_pop;
  logic       mem_buf_pop;
  logic       vrf_buf_pop;
  word_t      buf_rdata;
  logic [1:0] buf_rlane;
  logic       buf_empty;
  logic       buf_full;
  logic       buf_grant;

  // Stores pop on the memory side, loads on the register side
  assign buf_pop = mem_buf_pop | vrf_buf_pop;

  vlsu_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_load_i   (req_load_i),
    .req_strided_i(req_strided_i),
    .req_vsew_i   (req_vsew_i),
    .req_vl_i     (req_vl_i),
    .req_vd_i     (req_vd_i),
    .req_base_i   (req_base_i),
    .req_stride_i (req_stride_i),
    .mem_done_i   (mem_done),
    .vrf_done_i   (vrf_done),
    .start_o      (start),
    .op_load_o    (op_load),
    .op_vsew_o    (op_vsew),
    .op_vl_o      (op_vl),
    .op_vd_o      (op_vd),
    .op_base_o    (op_base),
    .op_stride_o  (op_stride),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_vd_o     (rsp_vd_o)
  );

  vlsu_mem_seq u_mem_seq (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_i      (start),
    .op_load_i    (op_load),
    .op_vsew_i    (op_vsew),
    .op_vl_i      (op_vl),
    .op_base_i    (op_base),
    .op_stride_i  (op_stride),
    .mem_valid_o  (mem_valid_o),
    .mem_ready_i  (mem_ready_i),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_strb_o   (mem_strb_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rvalid_i (mem_rvalid_i),
    .buf_grant_i  (buf_grant),
    .buf_empty_i  (buf_empty),
    .buf_rdata_i  (buf_rdata),
    .buf_reserve_o(buf_reserve),
    .buf_pop_o    (mem_buf_pop),
    .buf_lane_o   (buf_wlane),
    .done_o       (mem_done)
  );

  vlsu_vrf_seq u_vrf_seq (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (start),
    .op_load_i   (op_load),
    .op_vsew_i   (op_vsew),
    .op_vl_i     (op_vl),
    .op_vd_i     (op_vd),
    .vrf_we_o    (vrf_we_o),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wbe_o   (vrf_wbe_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_re_o    (vrf_re_o),
    .vrf_raddr_o (vrf_raddr_o),
    .vrf_rvalid_i(vrf_rvalid_i),
    .vrf_rdata_i (vrf_rdata_i),
    .mem_rvalid_i(mem_rvalid_i),
    .mem_rdata_i (mem_rdata_i),
    .buf_empty_i (buf_empty),
    .buf_full_i  (buf_full),
    .buf_rdata_i (buf_rdata),
    .buf_lane_i  (buf_rlane),
    .buf_push_o  (buf_push),
    .buf_wdata_o (buf_wdata),
    .buf_pop_o   (vrf_buf_pop),
    .done_o      (vrf_done)
  );

  vlsu_elem_buffer u_elem_buffer (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .push_i   (buf_push),
    .wdata_i  (buf_wdata),
    .wlane_i  (buf_wlane),
    .reserve_i(buf_reserve),
    .pop_i    (buf_pop),
    .rdata_o  (buf_rdata),
    .rlane_o  (buf_rlane),
    .empty_o  (buf_empty),
    .full_o   (buf_full),
    .grant_o  (buf_grant)
  );

endmodule

// File: design/vlsu_vrf_seq.sv
`timescale 1ns/1ps

module vlsu_vrf_seq import vlsu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Operation
  input  logic       start_i,
  input  logic       op_load_i,
  input  ew_e        op_vsew_i,
  input  elem_cnt_t  op_vl_i,
  input  vreg_id_t   op_vd_i,
  // Register file write
  output logic       vrf_we_o,
  output vrf_addr_t  vrf_waddr_o,
  output strb_t      vrf_wbe_o,
  output word_t      vrf_wdata_o,
  // Register file read
  output logic       vrf_re_o,
  output vrf_addr_t  vrf_raddr_o,
  input  logic       vrf_rvalid_i,
  input  word_t      vrf_rdata_i,
  // Load responses feed the buffer directly
  input  logic       mem_rvalid_i,
  input  word_t      mem_rdata_i,
  // Element buffer
  input  logic       buf_empty_i,
  input  logic       buf_full_i,
  input  word_t      buf_rdata_i,
  input  logic [1:0] buf_lane_i,
  output logic       buf_push_o,
  output word_t      buf_wdata_o,
  output logic       buf_pop_o,
  output logic       done_o
);

  elem_cnt_t  cnt_q;
  logic       rd_pend_q;
  elem_cnt_t  byte_off;
  vrf_addr_t  vaddr;
  logic [1:0] vrf_lane;
  logic [1:0] load_rot;
  logic [1:0] store_rot;
  logic       more_elems;
  logic       st_push;
  strb_t      mask;
  word_t      st_elem;

  assign more_elems = (cnt_q < op_vl_i);
  assign mask       = ew_mask(op_vsew_i);

  // Element k starts at byte k * size of register vd
  assign byte_off = cnt_q << op_vsew_i;
  assign vrf_lane = byte_off[1:0];
  assign vaddr    = (vrf_addr_t'(op_vd_i) << $clog2(WordsPerVreg))
                  | vrf_addr_t'(byte_off >> $clog2(DataBytes));

  assign vrf_waddr_o = vaddr;
  assign vrf_raddr_o = vaddr;

  //////////////////////////////
  // Load path
  //////////////////////////////

  assign vrf_we_o    = op_load_i & more_elems & !buf_empty_i;
  // Move the element from its memory lane to its register lane
  assign load_rot    = vrf_lane - buf_lane_i;
  assign vrf_wdata_o = rotl_bytes(buf_rdata_i, load_rot);
  assign vrf_wbe_o   = mask << vrf_lane;
  assign buf_pop_o   = vrf_we_o;

  //////////////////////////////
  // Store path
  //////////////////////////////

  // One read at a time, and only with room to take its answer
  assign vrf_re_o  = !op_load_i & more_elems & !buf_full_i & !rd_pend_q;
  assign st_push   = !op_load_i & rd_pend_q & vrf_rvalid_i;
  assign store_rot = 2'd0 - vrf_lane;

  // Right align the element and clear the other bytes
  always_comb begin
    st_elem = rotl_bytes(vrf_rdata_i, store_rot);
    for (int b = 0; b < DataBytes; b++) begin
      if (!mask[b]) begin
        st_elem[8*b +: 8] = '0;
      end
    end
  end

  assign buf_push_o  = op_load_i ? mem_rvalid_i : st_push;
  assign buf_wdata_o = op_load_i ? mem_rdata_i : st_elem;

  // Stores count on the answer, so nothing is left pending here
  assign done_o = !more_elems;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q     <= '0;
      rd_pend_q <= 1'b0;
    end else begin
      if (start_i) begin
        cnt_q <= '0;
      end else if (vrf_we_o || st_push) begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (vrf_re_o) begin
        rd_pend_q <= 1'b1;
      end else if (vrf_rvalid_i) begin
        rd_pend_q <= 1'b0;
      end
    end
  end

endmodule

// File: filelist.f
design/vlsu_pkg.sv
design/vlsu_ctrl.sv
design/vlsu_mem_seq.sv
design/vlsu_vrf_seq.sv
design/vlsu_elem_buffer.sv
design/vlsu_top.sv
tests/vlsu_mem_model.sv
tests/tb_vlsu.sv

// File: tests/tb_vlsu.sv
`timescale 1ns/1ps

module tb_vlsu import vlsu_pkg::*; ();

  localparam int          ClkPeriod   = 4;
  localparam int          DriveDelay  = 1;
  localparam int          ResetCycles = 10;
  localparam int          MemBytes    = 256;
  localparam int unsigned Seed        = 32'hd26a_dd2e;
  // Sum of vl over all tests, 40 cycles per element plus margin
  localparam int          TotalVl     = 4 + 16 + 8 + 10 + 16 + 10 + 4 + 0;
  localparam int          WatchdogCyc = TotalVl * 40 + 500;
  localparam int          WaitLimit   = 16 * 40;

  logic      clk;
  logic      rst_n;
  logic      rand_ready;
  logic      req_valid, req_ready, req_load, req_strided;
  ew_e       req_vsew;
  elem_cnt_t req_vl;
  vreg_id_t  req_vd;
  addr_t     req_base, req_stride;
  logic      rsp_valid;
  vreg_id_t  rsp_vd;
  logic      mem_valid, mem_ready, mem_we, mem_rvalid;
  addr_t     mem_addr;
  strb_t     mem_strb;
  word_t     mem_wdata, mem_rdata;
  logic      vrf_we, vrf_re, vrf_rvalid;
  vrf_addr_t vrf_waddr, vrf_raddr;
  strb_t     vrf_wbe;
  word_t     vrf_wdata, vrf_rdata;

  word_t       vrf [NrVregs*WordsPerVreg];
  vrf_addr_t   rd_addr_q;
  int unsigned rd_wait_q;
  logic [7:0]  mem_ref [MemBytes];
  int          activity;

  vlsu_top u_vlsu_top (
    .clk_i(clk), .rst_n_i(rst_n),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_load_i(req_load),
    .req_strided_i(req_strided), .req_vsew_i(req_vsew), .req_vl_i(req_vl),
    .req_vd_i(req_vd), .req_base_i(req_base), .req_stride_i(req_stride),
    .rsp_valid_o(rsp_valid), .rsp_vd_o(rsp_vd),
    .mem_valid_o(mem_valid), .mem_ready_i(mem_ready), .mem_we_o(mem_we),
    .mem_addr_o(mem_addr), .mem_strb_o(mem_strb), .mem_wdata_o(mem_wdata),
    .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata),
    .vrf_we_o(vrf_we), .vrf_waddr_o(vrf_waddr), .vrf_wbe_o(vrf_wbe),
    .vrf_wdata_o(vrf_wdata), .vrf_re_o(vrf_re), .vrf_raddr_o(vrf_raddr),
    .vrf_rvalid_i(vrf_rvalid), .vrf_rdata_i(vrf_rdata)
  );

  vlsu_mem_model #(.MemBytes(MemBytes)) u_mem_model (
    .clk_i(clk), .rst_n_i(rst_n), .rand_ready_i(rand_ready),
    .valid_i(mem_valid), .ready_o(mem_ready), .we_i(mem_we), .addr_i(mem_addr),
    .strb_i(mem_strb), .wdata_i(mem_wdata), .rvalid_o(mem_rvalid), .rdata_o(mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(WatchdogCyc * ClkPeriod);
    $display("Watchdog: the run timed out after %0d cycles", WatchdogCyc);
    abort_run();
  end

  //////////////////////////////
  // Register file model
  //////////////////////////////

  // Reads answer after 1 to 3 cycles, writes land at the clock edge
  always @(posedge clk) begin
    if (!rst_n) begin
      vrf_rvalid <= #DriveDelay 1'b0;
      rd_wait_q = 0;
    end else begin
      if (vrf_we) begin
        for (int b = 0; b < DataBytes; b++) begin
          if (vrf_wbe[b]) begin
            vrf[vrf_waddr][8*b +: 8] = vrf_wdata[8*b +: 8];
          end
        end
      end
      vrf_rvalid <= #DriveDelay 1'b0;
      if (rd_wait_q != 0) begin
        rd_wait_q = rd_wait_q - 1;
        if (rd_wait_q == 0) begin
          vrf_rvalid <= #DriveDelay 1'b1;
          vrf_rdata  <= #DriveDelay vrf[rd_addr_q];
        end
      end else if (vrf_re) begin
        rd_addr_q = vrf_raddr;
        rd_wait_q = 1 + ($urandom % 3);
      end
    end
  end

  // Any memory or register file traffic
  always @(posedge clk) begin
    if (rst_n && (mem_valid || vrf_we || vrf_re)) begin
      activity++;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "Run stopped on the first failure");
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_vd(string name, vreg_id_t exp, vreg_id_t act);
    if (act !== exp) begin
      $display("Error: %s expected vd %0d actual vd %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Error: %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  function automatic logic [7:0] vrf_byte(vreg_id_t vd, int off);
    return vrf[vd * WordsPerVreg + off / DataBytes][8 * (off % DataBytes) +: 8];
  endfunction

  //////////////////////////////
  // Request handling
  //////////////////////////////

  task automatic drive_req(logic load, logic strided, ew_e vsew, elem_cnt_t vl,
                           vreg_id_t vd, addr_t base, addr_t stride);
    req_valid   = 1'b1;
    req_load    = load;
    req_strided = strided;
    req_vsew    = vsew;
    req_vl      = vl;
    req_vd      = vd;
    req_base    = base;
    req_stride  = stride;
  endtask

  task automatic wait_accept(string name, output int edges);
    logic accepted;
    edges    = 0;
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      edges++;
      accepted = req_ready;
      if (!accepted && edges >= WaitLimit) begin
        $display("%s: the request was never accepted", name);
        abort_run();
      end
    end
    #DriveDelay;
    req_valid = 1'b0;
  endtask

  // Ready must stay low on every edge up to and including the response
  task automatic wait_rsp(string name, vreg_id_t exp_vd, output int edges);
    logic seen;
    edges = 0;
    seen  = 1'b0;
    while (!seen) begin
      @(posedge clk);
      edges++;
      check_flag({name, " ready while busy"}, 1'b0, req_ready);
      seen = rsp_valid;
      if (!seen && edges >= WaitLimit) begin
        $display("%s: no response arrived", name);
        abort_run();
      end
    end
    check_vd(name, exp_vd, rsp_vd);
    #DriveDelay;
  endtask

  task automatic run_op(string name, logic load, logic strided, ew_e vsew, elem_cnt_t vl,
                        vreg_id_t vd, addr_t base, addr_t stride);
    int edges;
    drive_req(load, strided, vsew, vl, vd, base, stride);
    wait_accept(name, edges);
    wait_rsp(name, vd, edges);
  endtask

  task automatic check_load(string name, ew_e vsew, int vl, vreg_id_t vd, addr_t base,
                            addr_t stride);
    int size;
    size = 1 << vsew;
    for (int k = 0; k < vl; k++) begin
      for (int b = 0; b < size; b++) begin
        check_byte(name, u_mem_model.mem[base + k * stride + b], vrf_byte(vd, k * size + b));
      end
    end
  endtask

  // Expected memory is the snapshot with the stored elements patched in
  task automatic check_store(string name, ew_e vsew, int vl, vreg_id_t vd, addr_t base,
                             addr_t stride);
    int size;
    size = 1 << vsew;
    for (int k = 0; k < vl; k++) begin
      for (int b = 0; b < size; b++) begin
        mem_ref[base + k * stride + b] = vrf_byte(vd, k * size + b);
      end
    end
    for (int a = 0; a < MemBytes; a++) begin
      check_byte(name, mem_ref[a], u_mem_model.mem[a]);
    end
  endtask

  task automatic snapshot_mem();
    for (int a = 0; a < MemBytes; a++) begin
      mem_ref[a] = u_mem_model.mem[a];
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_unit_load_w32();
    word_t exp;
    run_op("unit_load_w32", 1'b1, 1'b0, EW_32, 4, 3, 32'h40, 32'h0);
    for (int i = 0; i < 4; i++) begin
      exp = {u_mem_model.mem[32'h40 + 4*i + 3], u_mem_model.mem[32'h40 + 4*i + 2],
             u_mem_model.mem[32'h40 + 4*i + 1], u_mem_model.mem[32'h40 + 4*i]};
      check_word("unit_load_w32", exp, vrf[3 * WordsPerVreg + i]);
    end
  endtask

  task automatic test_strided_load_w8();
    run_op("strided_load_w8", 1'b1, 1'b1, EW_8, 16, 6, 32'h10, 32'd5);
    check_load("strided_load_w8", EW_8, 16, 6, 32'h10, 32'd5);
  endtask

  task automatic test_unit_store_w16();
    snapshot_mem();
    run_op("unit_store_w16", 1'b0, 1'b0, EW_16, 8, 5, 32'h80, 32'h0);
    check_store("unit_store_w16", EW_16, 8, 5, 32'h80, 32'd2);
  endtask

  task automatic test_strided_store_w8();
    snapshot_mem();
    run_op("strided_store_w8", 1'b0, 1'b1, EW_8, 10, 7, 32'ha0, 32'd3);
    check_store("strided_store_w8", EW_8, 10, 7, 32'ha0, 32'd3);
  endtask

  task automatic test_backpressure();
    rand_ready = 1'b1;
    run_op("backpressure_load", 1'b1, 1'b1, EW_8, 16, 9, 32'h20, 32'd5);
    check_load("backpressure_load", EW_8, 16, 9, 32'h20, 32'd5);
    snapshot_mem();
    run_op("backpressure_store", 1'b0, 1'b1, EW_8, 10, 10, 32'hc8, 32'd3);
    check_store("backpressure_store", EW_8, 10, 10, 32'hc8, 32'd3);
    rand_ready = 1'b0;
  endtask

  task automatic test_back_to_back();
    int edges;
    int start_activity;
    drive_req(1'b1, 1'b0, EW_32, 4, 12, 32'h60, 32'h0);
    wait_accept("back_to_back_first", edges);
    // Second request waits with valid high while the first is busy
    drive_req(1'b1, 1'b0, EW_32, 0, 21, 32'h0, 32'h0);
    wait_rsp("back_to_back_first", 12, edges);
    check_load("back_to_back_first", EW_32, 4, 12, 32'h60, 32'd4);
    start_activity = activity;
    wait_accept("back_to_back_vl0", edges);
    check_word("back_to_back_accept_edge", 1, word_t'(edges));
    wait_rsp("back_to_back_vl0", 21, edges);
    check_word("back_to_back_vl0_latency", 2, word_t'(edges));
    check_word("back_to_back_vl0_traffic", 0, word_t'(activity - start_activity));
  endtask

  initial begin
    void'($urandom(Seed));
    rst_n      = 1'b0;
    rand_ready = 1'b0;
    activity   = 0;
    vrf_rvalid = 1'b0;
    vrf_rdata  = '0;
    rd_wait_q  = 0;
    rd_addr_q  = '0;
    drive_req(1'b0, 1'b0, EW_8, 0, 0, 32'h0, 32'h0);
    req_valid = 1'b0;
    for (int i = 0; i < NrVregs * WordsPerVreg; i++) begin
      vrf[i] = (i * 32'h0101_0101) ^ 32'h5a3c_96e1;
    end

    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    rst_n = 1'b1;
    @(posedge clk);
    check_flag("after_reset ready", 1'b1, req_ready);
    check_flag("after_reset mem_valid", 1'b0, mem_valid);
    check_flag("after_reset vrf_we", 1'b0, vrf_we);
    check_flag("after_reset vrf_re", 1'b0, vrf_re);
    check_flag("after_reset rsp_valid", 1'b0, rsp_valid);
    #DriveDelay;

    test_unit_load_w32();
    test_strided_load_w8();
    test_unit_store_w16();
    test_strided_store_w8();
    test_backpressure();
    test_back_to_back();

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: tests/vlsu_mem_model.sv
`timescale 1ns/1ps

module vlsu_mem_model import vlsu_pkg::*; #(
  parameter int unsigned MemBytes = 256,
  parameter int unsigned Latency  = 2
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  rand_ready_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  logic  we_i,
  input  addr_t addr_i,
  input  strb_t strb_i,
  input  word_t wdata_i,
  output logic  rvalid_o,
  output word_t rdata_o
);

  logic [7:0]  mem [MemBytes];
  logic        rv_q [Latency];
  word_t       rd_q [Latency];
  word_t       rd_word;
  int unsigned idx;

  // Fill pattern is a bijection over the byte address
  initial begin
    ready_o = 1'b1;
    rd_word = '0;
    for (int i = 0; i < MemBytes; i++) begin
      mem[i] = 8'(i * 37 + 11);
    end
    for (int i = 0; i < Latency; i++) begin
      rv_q[i] = 1'b0;
      rd_q[i] = '0;
    end
  end

  assign rvalid_o = rv_q[Latency-1];
  assign rdata_o  = rd_q[Latency-1];

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      ready_o <= #1 1'b1;
      for (int i = 0; i < Latency; i++) begin
        rv_q[i] <= #1 1'b0;
      end
    end else begin
      if (valid_i && ready_o) begin
        idx = addr_i % MemBytes;
        if (we_i) begin
          for (int b = 0; b < DataBytes; b++) begin
            if (strb_i[b]) begin
              mem[idx + b] = wdata_i[8*b +: 8];
            end
          end
        end else begin
          rd_word = {mem[idx + 3], mem[idx + 2], mem[idx + 1], mem[idx]};
        end
      end
      // Fixed latency pipe, responses leave in issue order
      rv_q[0] <= #1 valid_i & ready_o & !we_i;
      rd_q[0] <= #1 rd_word;
      for (int i = 1; i < Latency; i++) begin
        rv_q[i] <= #1 rv_q[i-1];
        rd_q[i] <= #1 rd_q[i-1];
      end
      ready_o <= #1 rand_ready_i ? (($urandom % 2) != 0) : 1'b1;
    end
  end

endmodule
